//--- files.f
+incdir+design
design/lsu_pkg.sv
design/lsu_align.sv
design/lsu_ctrl.sv
design/axi_chan_slice.sv
design/axi_lite_sram.sv
design/lsu_subsys.sv
test/lsu_subsys_tb.sv

//--- Bender.yml
package:
  name: lsu_subsys

sources:
  - include_dirs:
      - design
    files:
      - design/lsu_pkg.sv
      - design/lsu_align.sv
      - design/lsu_ctrl.sv
      - design/axi_chan_slice.sv
      - design/axi_lite_sram.sv
      - design/lsu_subsys.sv
  - target: test
    files:
      - test/lsu_subsys_tb.sv

//--- test/lsu_stim.txt
# test op size sext addr wdata exp_data exp_err  (addr and data in hex)
# op 0 load, 1 store; size 0 byte, 1 half, 2 word; sext 1 sign-extends loads
1 0 2 0 80000000 00000000 00000000 0
1 0 2 0 800003fc 00000000 00000000 0
1 0 0 1 80000101 00000000 00000000 0
2 1 2 0 80000010 12345678 00000000 0
2 1 2 0 80000014 deadbeef 00000000 0
2 0 2 0 80000010 00000000 12345678 0
2 0 2 0 80000014 00000000 deadbeef 0
3 1 0 0 80000020 000000a1 00000000 0
3 1 0 0 80000022 000000c3 00000000 0
3 0 2 0 80000020 00000000 00c300a1 0
3 1 1 0 80000022 0000b7e5 00000000 0
3 1 0 0 80000021 ffffff5a 00000000 0
3 1 0 0 80000023 00000077 00000000 0
3 0 2 0 80000020 00000000 77e55aa1 0
3 1 1 0 80000024 1234abcd 00000000 0
3 0 2 0 80000024 00000000 0000abcd 0
4 1 2 0 80000030 80ff7f01 00000000 0
4 0 0 1 80000030 00000000 00000001 0
4 0 0 1 80000032 00000000 ffffffff 0
4 0 0 1 80000033 00000000 ffffff80 0
4 0 0 0 80000032 00000000 000000ff 0
4 0 0 0 80000033 00000000 00000080 0
4 0 1 1 80000030 00000000 00007f01 0
4 0 1 1 80000032 00000000 ffff80ff 0
4 0 1 0 80000032 00000000 000080ff 0
5 0 2 0 00001000 00000000 00000000 1
5 1 2 0 80000400 cafef00d 00000000 1
5 1 2 0 7ffffffc 0badf00d 00000000 1
5 0 2 0 80000000 00000000 00000000 0
5 0 2 0 800003fc 00000000 00000000 0
5 0 2 0 80000010 00000000 12345678 0
6 1 2 0 800003fc a5a55a5a 00000000 0
6 0 2 0 800003fc 00000000 a5a55a5a 0
6 1 1 0 800003fe 00001111 00000000 0
6 0 1 0 800003fe 00000000 00001111 0
6 0 0 1 800003fc 00000000 0000005a 0
6 0 2 0 800003fc 00000000 11115a5a 0

//--- test/lsu_subsys_tb.sv
`timescale 1ns/1ps

module lsu_subsys_tb;

  localparam int CLK_NS        = 40;
  localparam int CYCLES_PER_OP = 40;  // generous bound per access
  localparam int MARGIN_CYCLES = 50;

  logic              clock;
  logic              reset;
  logic              req;
  lsu_pkg::mem_req_t req_data;
  logic              ack;
  lsu_pkg::mem_rsp_t rsp;

  // accesses read from the stimulus file
  lsu_pkg::mem_req_t acc_req[$];
  lsu_pkg::mem_rsp_t acc_exp[$];
  int                acc_test[$];

  logic [31:0] rng_state;
  logic        loaded;
  int          check_errors;
  int          test_errors;
  int          test_accesses;
  int          tests_passed;
  int          tests_failed;

  lsu_subsys i_lsu_subsys (
    .clock    (clock),
    .reset    (reset),
    .req      (req),
    .req_data (req_data),
    .ack      (ack),
    .rsp      (rsp)
  );

  always #(CLK_NS / 2) clock = ~clock;

  // xorshift32 step
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
    test_errors++;
  endtask

  // ====================
  // stimulus file
  // ====================

  task automatic load_stimulus();
    int fd;
    int n;
    int tnum, op, size, sext, err;
    logic [31:0] addr, wdata, exp_data;
    logic [8*160-1:0] line;
    lsu_pkg::mem_req_t r;
    lsu_pkg::mem_rsp_t e;
    fd = $fopen("test/lsu_stim.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open stimulus file test/lsu_stim.txt");
      check_errors++;
    end else begin
      while ($fgets(line, fd)) begin
        n = $sscanf(line, "%d %d %d %d %h %h %h %d",
                    tnum, op, size, sext, addr, wdata, exp_data, err);
        if (n == 8) begin  // comment and blank lines fall through
          r.write = op[0];
          r.size  = lsu_pkg::lsu_size_e'(size[1:0]);
          r.sext  = sext[0];
          r.addr  = addr;
          r.wdata = wdata;
          e.rdata = exp_data;
          e.err   = err[0];
          acc_req.push_back(r);
          acc_exp.push_back(e);
          acc_test.push_back(tnum);
        end
      end
      $fclose(fd);
      if (acc_req.size() == 0) begin
        $display("error: stimulus file holds no accesses");
        check_errors++;
      end
    end
  endtask

  // ====================
  // core handshake
  // ====================

  // called and returns on a falling edge
  task automatic run_access(input lsu_pkg::mem_req_t r, input lsu_pkg::mem_rsp_t e);
    req_data = r;
    req      = 1'b1;
    do @(negedge clock); while (ack !== 1'b1);
    if (rsp.rdata !== e.rdata) report_mismatch("rsp.rdata", e.rdata, rsp.rdata);
    if (rsp.err !== e.err) report_mismatch("rsp.err", {31'd0, e.err}, {31'd0, rsp.err});
    req = 1'b0;
    do @(negedge clock); while (ack !== 1'b0);
    test_accesses++;
  endtask

  task automatic finish_test(input int tnum);
    if (test_errors == 0) begin
      $display("test %0d: %0d accesses, ok", tnum, test_accesses);
      tests_passed++;
    end else begin
      $display("test %0d: %0d accesses, %0d mismatches", tnum, test_accesses, test_errors);
      tests_failed++;
    end
    check_errors += test_errors;
    test_errors   = 0;
    test_accesses = 0;
  endtask

  initial begin : main
    int prev_test;
    clock         = 1'b0;
    reset         = 1'b1;
    req           = 1'b0;
    req_data      = '0;
    rng_state     = 32'he669;
    loaded        = 1'b0;
    check_errors  = 0;
    test_errors   = 0;
    test_accesses = 0;
    tests_passed  = 0;
    tests_failed  = 0;
    load_stimulus();
    loaded = 1'b1;
    repeat (5) @(negedge clock);
    reset = 1'b0;
    // ack must stay low with no request
    repeat (3) begin
      @(negedge clock);
      if (ack !== 1'b0) report_mismatch("ack", 32'd0, {31'd0, ack});
    end
    prev_test = (acc_test.size() > 0) ? acc_test[0] : 0;
    for (int i = 0; i < acc_req.size(); i++) begin
      if (acc_test[i] != prev_test) begin
        finish_test(prev_test);
        prev_test = acc_test[i];
      end
      run_access(acc_req[i], acc_exp[i]);
      rng_state = next_random(rng_state);
      repeat (rng_state[1:0]) @(negedge clock);  // 0 to 3 idle cycles
    end
    if (acc_req.size() > 0) finish_test(prev_test);
    $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
    if (check_errors == 0 && tests_failed == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // ====================
  // watchdog
  // ====================

  initial begin : watchdog
    longint limit_ns;
    wait (loaded === 1'b1);
    limit_ns = (longint'(acc_req.size()) * CYCLES_PER_OP + MARGIN_CYCLES) * CLK_NS;
    #(limit_ns);
    $display("timeout: ack never arrived, run stopped after %0d ns", limit_ns);
    $display("TEST FAILED");
    $finish;
  end

endmodule

//--- design/lsu_subsys.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module lsu_subsys (
  input  logic              clock,
  input  logic              reset,
  input  logic              req,
  input  lsu_pkg::mem_req_t req_data,
  output logic              ack,
  output lsu_pkg::mem_rsp_t rsp
);

  // lsu side of the slices
  logic lsu_ar_valid, lsu_ar_ready, lsu_r_valid, lsu_r_ready;
  logic lsu_aw_valid, lsu_aw_ready, lsu_w_valid, lsu_w_ready;
  logic lsu_b_valid, lsu_b_ready;
  lsu_pkg::axi_addr_t lsu_ar, lsu_aw;
  lsu_pkg::axi_r_t    lsu_r;
  lsu_pkg::axi_w_t    lsu_w;
  lsu_pkg::axi_b_t    lsu_b;

  // memory side
  logic mem_ar_valid, mem_ar_ready, mem_r_valid, mem_r_ready;
  logic mem_aw_valid, mem_aw_ready, mem_w_valid, mem_w_ready;
  logic mem_b_valid, mem_b_ready;
  lsu_pkg::axi_addr_t mem_ar, mem_aw;
  lsu_pkg::axi_r_t    mem_r;
  lsu_pkg::axi_w_t    mem_w;
  lsu_pkg::axi_b_t    mem_b;

  lsu_ctrl i_ctrl (
    .clock, .reset, .req, .req_data, .ack, .rsp,
    .ar_valid (lsu_ar_valid), .ar (lsu_ar), .ar_ready (lsu_ar_ready),
    .r_valid  (lsu_r_valid),  .r  (lsu_r),  .r_ready  (lsu_r_ready),
    .aw_valid (lsu_aw_valid), .aw (lsu_aw), .aw_ready (lsu_aw_ready),
    .w_valid  (lsu_w_valid),  .w  (lsu_w),  .w_ready  (lsu_w_ready),
    .b_valid  (lsu_b_valid),  .b  (lsu_b),  .b_ready  (lsu_b_ready)
  );

  // ====================
  // channel slices
  // ====================

  axi_chan_slice #(.payload_t(lsu_pkg::axi_addr_t)) i_ar_slice (
    .clock, .reset,
    .in_valid  (lsu_ar_valid), .in_data  (lsu_ar), .in_ready  (lsu_ar_ready),
    .out_valid (mem_ar_valid), .out_data (mem_ar), .out_ready (mem_ar_ready)
  );

  axi_chan_slice #(.payload_t(lsu_pkg::axi_r_t)) i_r_slice (  // memory to lsu
    .clock, .reset,
    .in_valid  (mem_r_valid), .in_data  (mem_r), .in_ready  (mem_r_ready),
    .out_valid (lsu_r_valid), .out_data (lsu_r), .out_ready (lsu_r_ready)
  );

  axi_chan_slice #(.payload_t(lsu_pkg::axi_addr_t)) i_aw_slice (
    .clock, .reset,
    .in_valid  (lsu_aw_valid), .in_data  (lsu_aw), .in_ready  (lsu_aw_ready),
    .out_valid (mem_aw_valid), .out_data (mem_aw), .out_ready (mem_aw_ready)
  );

  axi_chan_slice #(.payload_t(lsu_pkg::axi_w_t)) i_w_slice (
    .clock, .reset,
    .in_valid  (lsu_w_valid), .in_data  (lsu_w), .in_ready  (lsu_w_ready),
    .out_valid (mem_w_valid), .out_data (mem_w), .out_ready (mem_w_ready)
  );

  axi_chan_slice #(.payload_t(lsu_pkg::axi_b_t)) i_b_slice (  // memory to lsu
    .clock, .reset,
    .in_valid  (mem_b_valid), .in_data  (mem_b), .in_ready  (mem_b_ready),
    .out_valid (lsu_b_valid), .out_data (lsu_b), .out_ready (lsu_b_ready)
  );

  axi_lite_sram i_sram (
    .clock, .reset,
    .ar_valid (mem_ar_valid), .ar (mem_ar), .ar_ready (mem_ar_ready),
    .r_valid  (mem_r_valid),  .r  (mem_r),  .r_ready  (mem_r_ready),
    .aw_valid (mem_aw_valid), .aw (mem_aw), .aw_ready (mem_aw_ready),
    .w_valid  (mem_w_valid),  .w  (mem_w),  .w_ready  (mem_w_ready),
    .b_valid  (mem_b_valid),  .b  (mem_b),  .b_ready  (mem_b_ready)
  );

endmodule

//--- design/axi_lite_sram.sv
`timescale 1ns/1ps
`include "lsu_defs.svh"

module axi_lite_sram (
  input  logic                clock,
  input  logic                reset,

  input  logic                ar_valid,
  input  lsu_pkg::axi_addr_t  ar,
  output logic                ar_ready,

  output logic                r_valid,
  output lsu_pkg::axi_r_t     r,
  input  logic                r_ready,

  input  logic                aw_valid,
  input  lsu_pkg::axi_addr_t  aw,
  output logic                aw_ready,

  input  logic                w_valid,
  input  lsu_pkg::axi_w_t     w,
  output logic                w_ready,

  output logic                b_valid,
  output lsu_pkg::axi_b_t     b,
  input  logic                b_ready
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
  localparam logic [`LSU_XLEN-1:0] MEM_BYTES = `LSU_MEM_WORDS * 4;

  logic [`LSU_XLEN-1:0] mem [`LSU_MEM_WORDS];

  logic ar_fire, aw_fire, w_fire, wr_go;
  logic aw_got, w_got;
  logic [`LSU_XLEN-1:0] aw_addr_q;
  lsu_pkg::axi_w_t w_q;
  logic [`LSU_XLEN-1:0] wr_addr;
  lsu_pkg::axi_w_t wr_beat;

  function automatic logic mapped(input logic [`LSU_XLEN-1:0] addr);
    logic [`LSU_XLEN-1:0] off;
    off = addr - `LSU_MEM_BASE;
    return (addr >= `LSU_MEM_BASE) && (off < MEM_BYTES);
  endfunction

  function automatic logic [IDX_W-1:0] word_idx(input logic [`LSU_XLEN-1:0] addr);
    logic [`LSU_XLEN-1:0] off;
    off = addr - `LSU_MEM_BASE;
    return off[IDX_W+1:2];
  endfunction

  assign ar_fire = ar_valid && ar_ready;
  assign aw_fire = aw_valid && aw_ready;
  assign w_fire  = w_valid && w_ready;

  // AW and W may land in either order
  assign wr_go   = (aw_fire || w_fire) && (aw_got || aw_fire) && (w_got || w_fire);
  assign wr_addr = aw_fire ? aw.addr : aw_addr_q;
  assign wr_beat = w_fire ? w : w_q;

  // ====================
  // read channel
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      ar_ready <= 1'b0;
      r_valid  <= 1'b0;
    end else begin
      ar_ready <= ar_valid && !ar_ready && !r_valid;
      if (ar_fire) r_valid <= 1'b1;
      else if (r_ready) r_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      r.data <= mapped(ar.addr) ? mem[word_idx(ar.addr)] : '0;
      r.resp <= mapped(ar.addr) ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
    end
  end

  // ====================
  // write channels
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      b_valid  <= 1'b0;
      for (int i = 0; i < `LSU_MEM_WORDS; i++) mem[i] <= '0;
    end else begin
      aw_ready <= aw_valid && !aw_ready && !aw_got && !b_valid;
      w_ready  <= w_valid && !w_ready && !w_got && !b_valid;
      if (wr_go) begin
        aw_got  <= 1'b0;
        w_got   <= 1'b0;
        b_valid <= 1'b1;
        if (mapped(wr_addr)) begin
          for (int i = 0; i < 4; i++) begin
            if (wr_beat.strb[i]) mem[word_idx(wr_addr)][8*i +: 8] <= wr_beat.data[8*i +: 8];
          end
        end
      end else begin
        if (aw_fire) aw_got <= 1'b1;
        if (w_fire)  w_got  <= 1'b1;
        if (b_ready) b_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (aw_fire) aw_addr_q <= aw.addr;
    if (w_fire)  w_q <= w;
    if (wr_go)   b.resp <= mapped(wr_addr) ? `LSU_AXI_OKAY : `LSU_AXI_SLVERR;
  end

endmodule

//--- design/axi_chan_slice.sv
`timescale 1ns/1ps

module axi_chan_slice #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     reset,

  // upstream
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,

  // downstream
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  logic     full;
  payload_t data_q;
  logic     in_fire;

  // take a new beat when empty or when the held one leaves
  assign in_ready  = !full || out_ready;
  assign in_fire   = in_valid && in_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      full <= 1'b0;
    end else if (in_fire) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (in_fire) data_q <= in_data;
  end

endmodule

//--- design/lsu_ctrl.sv
`timescale 1ns/1ps

module lsu_ctrl (
  input  logic                clock,
  input  logic                reset,

  // core side
  input  logic                req,
  input  lsu_pkg::mem_req_t   req_data,
  output logic                ack,
  output lsu_pkg::mem_rsp_t   rsp,

  // read address
  output logic                ar_valid,
  output lsu_pkg::axi_addr_t  ar,
  input  logic                ar_ready,

  // read data
  input  logic                r_valid,
  input  lsu_pkg::axi_r_t     r,
  output logic                r_ready,

  // write address
  output logic                aw_valid,
  output lsu_pkg::axi_addr_t  aw,
  input  logic                aw_ready,

  // write data
  output logic                w_valid,
  output lsu_pkg::axi_w_t     w,
  input  logic                w_ready,

  // write response
  input  logic                b_valid,
  input  lsu_pkg::axi_b_t     b,
  output logic                b_ready
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_RADDR,
    S_RDATA,
    S_WADDR,
    S_WDATA,
    S_WRESP,
    S_RELEASE
  } state_t;

  state_t state;
  lsu_pkg::mem_req_t req_q;
  logic [31:0] load_value;
  logic r_fire;
  logic b_fire;

  lsu_align i_align (
    .req        (req_q),
    .rdata      (r.data),
    .wbeat      (w),
    .load_value (load_value)
  );

  // at most one transaction in flight so responses are always accepted
  assign r_ready = 1'b1;
  assign b_ready = 1'b1;

  assign r_fire = r_valid && r_ready;
  assign b_fire = b_valid && b_ready;

  assign ar.addr = req_q.addr;
  assign aw.addr = req_q.addr;

  // ====================
  // sequencing
  // ====================

  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= S_IDLE;
      ack      <= 1'b0;
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (req) begin
            if (req_data.write) begin
              aw_valid <= 1'b1;
              state    <= S_WADDR;
            end else begin
              ar_valid <= 1'b1;
              state    <= S_RADDR;
            end
          end
        end
        S_RADDR: begin
          if (ar_ready) begin
            ar_valid <= 1'b0;
            state    <= S_RDATA;
          end
        end
        S_RDATA: if (r_fire) state <= S_RELEASE;
        S_WADDR: begin
          if (aw_ready) begin
            aw_valid <= 1'b0;
            w_valid  <= 1'b1;  // data follows address
            state    <= S_WDATA;
          end
        end
        S_WDATA: begin
          if (w_ready) begin
            w_valid <= 1'b0;
            state   <= S_WRESP;
          end
        end
        S_WRESP: if (b_fire) state <= S_RELEASE;
        S_RELEASE: begin
          if (!ack) begin
            ack <= 1'b1;
          end else if (!req) begin  // four-phase return to zero
            ack   <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // request and response payloads
  always_ff @(posedge clock) begin
    if (state == S_IDLE && req) req_q <= req_data;
    if (state == S_RDATA && r_fire) begin
      rsp.rdata <= load_value;
      rsp.err   <= r.resp[1];  // SLVERR or DECERR
    end else if (state == S_WRESP && b_fire) begin
      rsp.rdata <= 32'b0;
      rsp.err   <= b.resp[1];
    end
  end

endmodule

//--- design/lsu_align.sv
`timescale 1ns/1ps

module lsu_align (
  input  lsu_pkg::mem_req_t req,
  input  logic [31:0]       rdata,
  output lsu_pkg::axi_w_t   wbeat,
  output logic [31:0]       load_value
);

  logic [1:0]  offset;
  logic [4:0]  bit_shift;
  logic [3:0]  strb_base;
  logic [31:0] shifted;

  assign offset    = req.addr[1:0];
  assign bit_shift = {offset, 3'b000};

  // store side
  always_comb begin
    case (req.size)
      lsu_pkg::SIZE_B: strb_base = 4'b0001;
      lsu_pkg::SIZE_H: strb_base = 4'b0011;
      default:         strb_base = 4'b1111;
    endcase
  end

  assign wbeat.data = req.wdata << bit_shift;
  assign wbeat.strb = strb_base << offset;

  // load side
  assign shifted = rdata >> bit_shift;

  always_comb begin
    case (req.size)
      lsu_pkg::SIZE_B: begin
        if (req.sext) load_value = {{24{shifted[7]}}, shifted[7:0]};
        else          load_value = {24'b0, shifted[7:0]};
      end
      lsu_pkg::SIZE_H: begin
        if (req.sext) load_value = {{16{shifted[15]}}, shifted[15:0]};
        else          load_value = {16'b0, shifted[15:0]};
      end
      default: load_value = shifted;  // full word
    endcase
  end

endmodule

//--- design/lsu_pkg.sv
package lsu_pkg;

  // byte, half or word access
  typedef enum logic [1:0] {
    SIZE_B = 2'd0,
    SIZE_H = 2'd1,
    SIZE_W = 2'd2
  } lsu_size_e;

  // core request of 68 bits
  typedef struct packed {
    logic        write;
    lsu_size_e   size;
    logic        sext;  // sign-extend loads
    logic [31:0] addr;
    logic [31:0] wdata;
  } mem_req_t;

  // core response of 33 bits
  typedef struct packed {
    logic [31:0] rdata;
    logic        err;
  } mem_rsp_t;

  // ====================
  // AXI4-Lite payloads
  // ====================

  typedef struct packed {
    logic [31:0] addr;
  } axi_addr_t;

  typedef struct packed {
    logic [31:0] data;
    logic [3:0]  strb;
  } axi_w_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  typedef struct packed {
    logic [1:0] resp;
  } axi_b_t;

endpackage

//--- design/lsu_defs.svh
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// ====================
// data path
// ====================

`define LSU_XLEN 32

// ====================
// memory map
// ====================

`define LSU_MEM_WORDS 256
`define LSU_MEM_BASE 32'h8000_0000

// AXI response codes
`define LSU_AXI_OKAY 2'b00
`define LSU_AXI_SLVERR 2'b10

`endif
